// File: Bender.yml
package:
  name: audio_processing

sources:
  - files:
      - hdl/audio_pkg.sv
      - hdl/i2s_to_pcm.sv
      - hdl/channel_gain.sv
      - hdl/sample_fifo.sv
      - hdl/pcm_to_i2s.sv
      - hdl/audio_processing.sv
  - target: test
    files:
      - verification/audio_processing_checker.sv
      - verification/tb_audio_processing.sv

// File: hdl/audio_pkg.sv
package audio_pkg;

    ////////////////// sample format //////////////////

    localparam int sample_width = 24;       // pcm word bits per channel

    // one stereo frame worth of pcm
    typedef struct packed {
        logic signed [sample_width-1:0] left;   // lrclk low slot
        logic signed [sample_width-1:0] right;  // lrclk high slot
    } stereo_sample_t;

    ////////////////// gain format ////////////////////

    // unsigned 2.14 fixed point
    localparam int gain_width     = 16;
    localparam int gain_frac_bits = 14;     // shift after multiply

    localparam logic [gain_width-1:0] gain_unity = 16'h4000;   // 1.0

    // signed sample times zero extended gain
    localparam int prod_width = sample_width + gain_width + 1;

    ////////////////// sample fifo ////////////////////

    localparam int fifo_depth     = 4;
    localparam int fifo_ptr_width = 2;      // log2 of depth

    ////////////////// i2s timing /////////////////////

    // both directions use 32 bit slots
    localparam int slot_bits  = 32;         // bclk periods per channel
    localparam int frame_bits = 64;         // left plus right slot

    // dac bclk half period in clk cycles
    // 8 clk per bclk so 512 clk per dac frame
    localparam int bclk_half_period = 4;

    ////////////////// cpu registers //////////////////

    // audio_status bits
    localparam int stat_overflow   = 0;     // sticky fifo drop
    localparam int stat_underflow  = 1;     // sticky empty pop
    localparam int stat_fifo_empty = 2;
    localparam int stat_bit_cnt_ok = 3;     // input slot length matches

    // audio_control bits
    localparam int ctrl_enable = 0;         // run the audio path
    localparam int ctrl_bypass = 1;         // skip gain scaling
    localparam int ctrl_clear  = 2;         // clear sticky flags

endpackage

// File: hdl/audio_processing.sv
`timescale 1ns/10ps

module audio_processing (
    input  logic       clk,
    input  logic       rst_n,
    // i2s in
    input  logic       i2s_bclk,
    input  logic       i2s_lrclk,
    input  logic       i2s_d,
    // cpu registers
    input  logic [7:0] audio_control,
    input  logic [7:0] gain_select,
    input  logic [7:0] gain_lsb,
    input  logic [7:0] gain_msb,
    input  logic       gain_wr_en,
    // dac i2s out
    output logic       dac_bclk,
    output logic       dac_lrclk,
    output logic       dac_data,
    output logic [7:0] audio_status,
    output logic [7:0] i2s_bit_cnt
);
    import audio_pkg::*;

    logic           audio_enable;
    logic           audio_bypass;
    logic           fifo_clear;
    logic           rx_valid;
    stereo_sample_t rx_sample;
    logic           gain_valid;
    stereo_sample_t gain_sample;
    stereo_sample_t head_sample;
    logic           fifo_pop;
    logic           fifo_empty;
    logic           fifo_overflow;
    logic           fifo_underflow;
    logic [7:0]     status_next;

    ////////////////// control register ///////////////

    assign audio_enable = audio_control[ctrl_enable];
    assign audio_bypass = audio_control[ctrl_bypass];
    assign fifo_clear   = audio_control[ctrl_clear];   // level while set

    ////////////////// audio chain ////////////////////

    i2s_to_pcm i2s_to_pcm_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (audio_enable),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_d     (i2s_d),
        .rx_valid  (rx_valid),
        .rx_sample (rx_sample),
        .bit_cnt   (i2s_bit_cnt)
    );

    channel_gain channel_gain_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bypass      (audio_bypass),
        .gain_wr_en  (gain_wr_en),
        .gain_select (gain_select[1:0]),   // upper bits unused
        .gain_lsb    (gain_lsb),
        .gain_msb    (gain_msb),
        .rx_valid    (rx_valid),
        .rx_sample   (rx_sample),
        .gain_valid  (gain_valid),
        .gain_sample (gain_sample)
    );

    sample_fifo sample_fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (fifo_clear),
        .wr_en       (gain_valid),
        .wr_sample   (gain_sample),
        .pop         (fifo_pop),
        .head_sample (head_sample),
        .fifo_empty  (fifo_empty),
        .overflow    (fifo_overflow),
        .underflow   (fifo_underflow)
    );

    pcm_to_i2s pcm_to_i2s_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (audio_enable),
        .head_sample (head_sample),
        .pop         (fifo_pop),
        .dac_bclk    (dac_bclk),
        .dac_lrclk   (dac_lrclk),
        .dac_data    (dac_data)
    );

    ////////////////// status register ////////////////

    always_comb begin
        status_next                  = '0;
        status_next[stat_overflow]   = fifo_overflow;
        status_next[stat_underflow]  = fifo_underflow;
        status_next[stat_fifo_empty] = fifo_empty;
        status_next[stat_bit_cnt_ok] = (i2s_bit_cnt == 8'(slot_bits));  // input format check
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            audio_status <= '0;
        else
            audio_status <= status_next;
    end

endmodule

// File: hdl/channel_gain.sv
`timescale 1ns/10ps

module channel_gain (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      bypass,       // pass samples unchanged
    input  logic                      gain_wr_en,   // cpu write strobe
    input  logic [1:0]                gain_select,  // bit 0 left and bit 1 right
    input  logic [7:0]                gain_lsb,
    input  logic [7:0]                gain_msb,
    input  logic                      rx_valid,
    input  audio_pkg::stereo_sample_t rx_sample,
    output logic                      gain_valid,   // rx_valid plus 2 clk
    output audio_pkg::stereo_sample_t gain_sample
);
    import audio_pkg::*;

    logic [gain_width-1:0]        gain_l;
    logic [gain_width-1:0]        gain_r;
    logic signed [prod_width-1:0] prod_l;
    logic signed [prod_width-1:0] prod_r;
    logic                         s1_valid;
    logic                         s1_bypass;    // follows its sample
    stereo_sample_t               s1_sample;    // raw copy for bypass

    // round half up then drop fraction and clamp to 24 bits
    function automatic logic signed [sample_width-1:0] round_sat(
        input logic signed [prod_width-1:0] prod
    );
        logic signed [prod_width-1:0]   rounded;
        logic signed [prod_width-1:0]   shifted;
        logic [prod_width-sample_width:0] upper;
        rounded = prod + $signed(prod_width'(1) << (gain_frac_bits - 1));
        shifted = rounded >>> gain_frac_bits;
        upper   = shifted[prod_width-1:sample_width-1];
        if (&upper || ~|upper)
            round_sat = shifted[sample_width-1:0];             // in range
        else if (upper[prod_width-sample_width])
            round_sat = {1'b1, {(sample_width-1){1'b0}}};      // most negative
        else
            round_sat = {1'b0, {(sample_width-1){1'b1}}};      // most positive
    endfunction

    ////////////////// gain registers /////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gain_l <= gain_unity;
            gain_r <= gain_unity;
        end else if (gain_wr_en) begin
            if (gain_select[0])
                gain_l <= {gain_msb, gain_lsb};
            if (gain_select[1])
                gain_r <= {gain_msb, gain_lsb};
        end
    end

    ////////////////// two stage scaler ///////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            gain_valid <= 1'b0;
        end else begin
            s1_valid   <= rx_valid;
            gain_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        // stage one multiply
        prod_l    <= rx_sample.left * $signed({1'b0, gain_l});
        prod_r    <= rx_sample.right * $signed({1'b0, gain_r});
        s1_sample <= rx_sample;
        s1_bypass <= bypass;
        // stage two round and saturate
        if (s1_bypass) begin
            gain_sample <= s1_sample;
        end else begin
            gain_sample.left  <= round_sat(prod_l);
            gain_sample.right <= round_sat(prod_r);
        end
    end

endmodule

// File: hdl/i2s_to_pcm.sv
`timescale 1ns/10ps

module i2s_to_pcm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,       // no strobes while low
    input  logic                      i2s_bclk,     // async to clk
    input  logic                      i2s_lrclk,    // low selects left
    input  logic                      i2s_d,
    output logic                      rx_valid,     // one cycle per frame
    output audio_pkg::stereo_sample_t rx_sample,
    output logic [7:0]                bit_cnt       // bclk rises in last slot
);
    import audio_pkg::*;

    logic [2:0]              bclk_sync;     // two sync flops plus history
    logic [2:0]              lrclk_sync;
    logic [1:0]              data_sync;     // lines up with bclk_sync[1]
    logic                    bclk_rise;
    logic                    lrclk_edge;
    logic                    slot_right;
    logic                    bit_capture;
    logic                    word_done;
    logic [7:0]              slot_cnt;      // rises seen in current slot
    logic [sample_width-1:0] shift_word;
    logic [sample_width-1:0] next_word;
    logic [sample_width-1:0] left_word;     // waits for the right slot

    ////////////////// input sync /////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            data_sync  <= '0;
        end else begin
            bclk_sync  <= {bclk_sync[1:0], i2s_bclk};
            lrclk_sync <= {lrclk_sync[1:0], i2s_lrclk};
            data_sync  <= {data_sync[0], i2s_d};
        end
    end

    assign bclk_rise  = bclk_sync[1] & ~bclk_sync[2];
    assign lrclk_edge = lrclk_sync[1] ^ lrclk_sync[2];
    assign slot_right = lrclk_sync[1];

    // rise 0 is the delay bit and rises 1 to 24 carry data
    assign bit_capture = bclk_rise && (slot_cnt != 8'd0) && (slot_cnt <= 8'(sample_width));
    assign word_done   = bclk_rise && (slot_cnt == 8'(sample_width));
    assign next_word   = {shift_word[sample_width-2:0], data_sync[1]};   // msb first

    ////////////////// slot length ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_cnt <= '0;
            bit_cnt  <= '0;
        end else if (lrclk_edge) begin
            bit_cnt  <= slot_cnt;                   // publish finished slot
            slot_cnt <= '0;
        end else if (bclk_rise && slot_cnt != 8'hff) begin
            slot_cnt <= slot_cnt + 8'd1;            // saturate if lrclk stalls
        end
    end

    ////////////////// deserializer ///////////////////

    always_ff @(posedge clk) begin
        if (bit_capture)
            shift_word <= next_word;
        if (word_done && !slot_right)
            left_word <= next_word;
        // both words out together after the right lsb
        if (word_done && slot_right && enable) begin
            rx_sample.left  <= left_word;
            rx_sample.right <= next_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            rx_valid <= 1'b0;
        else
            rx_valid <= word_done && slot_right && enable;  // 3 clk after bclk pin
    end

endmodule

// File: hdl/pcm_to_i2s.sv
`timescale 1ns/10ps

module pcm_to_i2s (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,       // pins held low when clear
    input  audio_pkg::stereo_sample_t head_sample,
    output logic                      pop,          // one pulse per frame
    output logic                      dac_bclk,
    output logic                      dac_lrclk,    // low selects left
    output logic                      dac_data
);
    import audio_pkg::*;

    logic [$clog2(bclk_half_period)-1:0] div_cnt;
    logic                  half_tick;       // last clk of a bclk half
    logic                  bclk_fall;
    logic                  frame_start;     // lrclk falls here
    logic [5:0]            bit_idx;         // bclk position in frame
    logic [frame_bits-1:0] tx_shift;        // msb drives the pin
    logic [frame_bits-1:0] frame_word;

    assign half_tick   = (int'(div_cnt) == bclk_half_period - 1);
    assign bclk_fall   = half_tick && dac_bclk;
    assign frame_start = bclk_fall && (bit_idx == 6'(frame_bits - 1));

    // slot order with one delay bit per slot and zero padding
    assign frame_word = {1'b0, head_sample.left,
                         {(slot_bits - sample_width){1'b0}},
                         head_sample.right,
                         {(slot_bits - sample_width - 1){1'b0}}};

    ////////////////// bclk divider ///////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || !enable) begin
            div_cnt  <= '0;
            dac_bclk <= 1'b0;
        end else begin
            if (half_tick) begin
                div_cnt  <= '0;
                dac_bclk <= ~dac_bclk;
            end else begin
                div_cnt  <= div_cnt + 1'b1;
            end
        end
    end

    ////////////////// frame and shifter //////////////

    always_ff @(posedge clk) begin
        if (!rst_n || !enable) begin
            bit_idx  <= '0;
            tx_shift <= '0;
            pop      <= 1'b0;
        end else begin
            pop <= frame_start;                     // fifo moves one clk later
            if (bclk_fall)
                bit_idx <= bit_idx + 6'd1;          // wraps at 64
            if (frame_start)
                tx_shift <= frame_word;             // latch current head
            else if (bclk_fall)
                tx_shift <= {tx_shift[frame_bits-2:0], 1'b0};
        end
    end

    // second half of the frame is the right slot
    assign dac_lrclk = (bit_idx >= 6'(slot_bits));
    assign dac_data  = tx_shift[frame_bits-1];      // changes on bclk fall

endmodule

// File: hdl/sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear,        // drops sticky flags
    input  logic                      wr_en,
    input  audio_pkg::stereo_sample_t wr_sample,
    input  logic                      pop,          // advance head
    output audio_pkg::stereo_sample_t head_sample,  // show ahead
    output logic                      fifo_empty,
    output logic                      overflow,     // sticky
    output logic                      underflow     // sticky
);
    import audio_pkg::*;

    stereo_sample_t            mem [fifo_depth];
    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_ptr_width:0]   count;           // occupancy 0 to depth
    logic                      fifo_full;
    logic                      do_write;
    logic                      do_read;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == (fifo_ptr_width + 1)'(fifo_depth));
    assign do_write   = wr_en && (!fifo_full || pop);   // pop frees a slot
    assign do_read    = pop && !fifo_empty;

    // zeros when nothing is stored
    always_comb begin
        if (fifo_empty)
            head_sample = '0;
        else
            head_sample = mem[rd_ptr];
    end

    ////////////////// storage ////////////////////////

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= wr_sample;
    end

    ////////////////// pointers and count /////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;            // wraps at depth
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // idle or both
            endcase
        end
    end

    ////////////////// error flags ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (wr_en && !do_write)
                overflow <= 1'b1;                   // sample dropped
            if (pop && fifo_empty)
                underflow <= 1'b1;                  // zeros went out
        end
    end

endmodule

// File: src.f
hdl/audio_pkg.sv
hdl/i2s_to_pcm.sv
hdl/channel_gain.sv
hdl/sample_fifo.sv
hdl/pcm_to_i2s.sv
hdl/audio_processing.sv
verification/audio_processing_checker.sv
verification/tb_audio_processing.sv

// File: verification/audio_processing_checker.sv
`timescale 1ns/10ps

module audio_processing_checker (
    input logic       clk,
    input logic       rst_n,
    input logic [7:0] audio_control,
    input logic       pop,
    input logic       dac_bclk,
    input logic       dac_lrclk,
    input logic       dac_data
);
    import audio_pkg::*;

    ////////////////// dac pins ///////////////////////

    // transmitter resets on the edge that sees enable low
    assert property (@(posedge clk) disable iff (!rst_n)
        !audio_control[ctrl_enable] |=> !dac_bclk && !dac_lrclk && !dac_data)
        else $error("dac pins active while audio path disabled");

    // word select moves only with bclk low
    assert property (@(posedge clk) disable iff (!rst_n)
        $changed(dac_lrclk) |-> !dac_bclk)
        else $error("dac_lrclk changed while dac_bclk high");

    ////////////////// fifo pop ///////////////////////

    assert property (@(posedge clk) disable iff (!rst_n)
        pop |=> !pop)
        else $error("fifo pop held for two cycles");

endmodule

bind audio_processing audio_processing_checker checker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .audio_control (audio_control),
    .pop           (fifo_pop),
    .dac_bclk      (dac_bclk),
    .dac_lrclk     (dac_lrclk),
    .dac_data      (dac_data)
);

// File: verification/tb_audio_processing.sv
`timescale 1ns/10ps

module tb_audio_processing;
    import audio_pkg::*;

    // one row of the stimulus table
    typedef struct packed {
        logic                  enable;
        logic                  bypass;
        logic                  check_data;   // compare decoded words
        logic [gain_width-1:0] gain_l;
        logic [gain_width-1:0] gain_r;
        logic [7:0]            frames;
        logic [3:0]            half;         // source bclk half period in clk
        logic [7:0]            status_mask;  // bits expected set after the row
    } stim_row_t;

    localparam int num_rows  = 6;
    localparam int dac_frame_clk = frame_bits * 2 * bclk_half_period;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       i2s_bclk, i2s_lrclk, i2s_d;
    logic [7:0] audio_control, gain_select, gain_lsb, gain_msb;
    logic       gain_wr_en;
    logic       dac_bclk, dac_lrclk, dac_data;
    logic [7:0] audio_status, i2s_bit_cnt;

    stim_row_t      stim_rows [num_rows];
    stereo_sample_t expected_q [$];
    stereo_sample_t decoded_q [$];
    logic [31:0]    rng_state = 32'd97859;
    int             errors = 0;
    int             checks = 0;
    int             cycle_cnt = 0;
    int             timeout_limit;

    audio_processing audio_processing_i (.*);

    always #10 clk = ~clk;

    ////////////////// helpers ////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // 2.14 gain with half up rounding and a signed 24 bit clamp
    function automatic logic [sample_width-1:0] scale_channel(
        input logic [sample_width-1:0] s, input logic [gain_width-1:0] g, input logic byp
    );
        longint prod;
        longint q;
        if (byp)
            return s;
        prod = longint'($signed(s)) * longint'(g);
        q    = (prod + (longint'(1) <<< (gain_frac_bits - 1))) >>> gain_frac_bits;
        if (q > 64'sd8388607)
            q = 64'sd8388607;
        else if (q < -64'sd8388608)
            q = -64'sd8388608;
        return q[sample_width-1:0];
    endfunction

    function automatic logic [7:0] control_word(input logic en, input logic byp, input logic clr);
        control_word = '0;
        control_word[ctrl_enable] = en;
        control_word[ctrl_bypass] = byp;
        control_word[ctrl_clear]  = clr;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    ////////////////// table //////////////////////////

    task automatic fill_table();
        logic [7:0] base;
        logic [31:0] r0, r1, r2, r3;
        base = 8'(1 << stat_bit_cnt_ok) | 8'(1 << stat_underflow);  // start-up pops underflow
        r0 = next_rand();
        r1 = next_rand();
        r2 = next_rand();
        r3 = next_rand();
        //                en    byp   chk   gain_l                gain_r        frm  half mask
        stim_rows[0] = '{1'b1, 1'b1, 1'b1, 16'h2000, 16'h6000, 8'd6, 4'd4, base};  // gains ignored
        stim_rows[1] = '{1'b1, 1'b0, 1'b1, gain_unity, gain_unity, 8'd6, 4'd4, base};
        stim_rows[2] = '{1'b1, 1'b0, 1'b1, 16'h1000 + 16'(r0[13:0]),
                         16'h1000 + 16'(r1[13:0]), 8'd8, 4'd4, base};   // 0.25 to 1.25
        stim_rows[3] = '{1'b1, 1'b0, 1'b1, 16'h4000 + 16'(r2[14:0]),
                         16'h4000 + 16'(r3[14:0]), 8'd8, 4'd4, base};   // above 1.0 so big ones clip
        stim_rows[4] = '{1'b1, 1'b0, 1'b0, gain_unity, gain_unity, 8'd28, 4'd3,
                         base | 8'(1 << stat_overflow)};               // fast source fills fifo
        stim_rows[5] = '{1'b0, 1'b0, 1'b0, gain_unity, gain_unity, 8'd3, 4'd4,
                         8'(1 << stat_bit_cnt_ok) | 8'(1 << stat_fifo_empty)};
    endtask

    ////////////////// i2s source and dac decoder /////

    task automatic send_frame(input stereo_sample_t s, input int half);
        logic [sample_width-1:0] word;
        int pos;
        for (int i = 0; i < frame_bits; i++) begin
            pos  = i % slot_bits;
            word = (i < slot_bits) ? s.left : s.right;
            @(posedge clk);
            i2s_bclk  <= 1'b0;                          // data and lrclk move on the fall
            i2s_lrclk <= (i >= slot_bits);
            i2s_d     <= (pos >= 1 && pos <= sample_width) ? word[sample_width-pos] : 1'b0;
            repeat (half) @(posedge clk);
            i2s_bclk  <= 1'b1;
            repeat (half - 1) @(posedge clk);
        end
    endtask

    logic           bclk_q = 1'b0;
    logic           lrclk_q = 1'b0;
    logic [63:0]    dac_frame = '0;
    int             dac_bits = frame_bits;                   // idle until a frame start
    stereo_sample_t dac_word;

    always @(negedge clk) begin
        if (dac_bclk && !bclk_q) begin
            if (lrclk_q && !dac_lrclk)
                dac_bits = 0;                               // lrclk fell so bit 0 of a frame
            if (dac_bits < frame_bits) begin
                dac_frame = {dac_frame[62:0], dac_data};
                dac_bits  = dac_bits + 1;
                dac_word.left  = dac_frame[62:39];          // after the delay bit
                dac_word.right = dac_frame[30:7];
                if (dac_bits == frame_bits && dac_word != '0)
                    decoded_q.push_back(dac_word);          // empty fifo pops come out as zeros
            end
            lrclk_q = dac_lrclk;
        end
        bclk_q = dac_bclk;
    end

    ////////////////// row procedure //////////////////

    task automatic write_gain(input logic [1:0] sel, input logic [gain_width-1:0] g);
        @(posedge clk);
        gain_select <= {6'b0, sel};
        gain_lsb    <= g[7:0];
        gain_msb    <= g[15:8];
        gain_wr_en  <= 1'b1;
        @(posedge clk);
        gain_wr_en  <= 1'b0;
    endtask

    task automatic wait_dac_frames(input int n);
        int   seen;
        logic prev;
        seen = 0;
        @(negedge clk);
        prev = dac_lrclk;
        while (seen < n) begin
            @(negedge clk);
            if (prev && !dac_lrclk)
                seen++;
            prev = dac_lrclk;
        end
    endtask

    task automatic run_row(input stim_row_t r);
        stereo_sample_t s, e, got, want;
        logic [31:0] w;
        @(posedge clk);
        audio_control <= control_word(r.enable, r.bypass, 1'b0);
        write_gain(2'b01, r.gain_l);
        write_gain(2'b10, r.gain_r);
        for (int f = 0; f < r.frames; f++) begin
            w = next_rand();
            s.left  = w[23:0];
            w = next_rand();
            s.right = w[23:0];
            e.left  = scale_channel(s.left, r.gain_l, r.bypass);   // each channel on its own
            e.right = scale_channel(s.right, r.gain_r, r.bypass);
            if (r.check_data && e != '0)
                expected_q.push_back(e);
            send_frame(s, r.half);
        end
        if (r.enable) begin
            @(negedge clk);
            while (!audio_status[stat_fifo_empty])
                @(negedge clk);
            wait_dac_frames(2);                             // last popped frame fully shifted
        end
        @(negedge clk);
        if (r.check_data) begin
            check_value("decoded_frames", decoded_q.size(), expected_q.size());
            while (decoded_q.size() > 0 && expected_q.size() > 0) begin
                got  = decoded_q.pop_front();
                want = expected_q.pop_front();
                check_value("dac_left", $unsigned(got.left), $unsigned(want.left));
                check_value("dac_right", $unsigned(got.right), $unsigned(want.right));
            end
        end
        if (!r.enable) begin
            check_value("decoded_frames", decoded_q.size(), 0);
            check_value("dac_pins", {dac_bclk, dac_lrclk, dac_data}, 3'b000);
        end
        check_value("audio_status", audio_status & r.status_mask, r.status_mask);
        check_value("i2s_bit_cnt", i2s_bit_cnt, slot_bits);
        decoded_q.delete();
        expected_q.delete();
        // pulse clear and see both sticky flags drop
        @(posedge clk);
        audio_control <= control_word(r.enable, r.bypass, 1'b1);
        @(posedge clk);
        audio_control <= control_word(r.enable, r.bypass, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_value("audio_status_sticky", audio_status[1:0], 2'b00);
    endtask

    ////////////////// run and timeout ////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles, DUT never drained, errors %0d", cycle_cnt, errors);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        rst_n         = 1'b0;
        i2s_bclk      = 1'b0;                               // idle low so no stray rise
        i2s_lrclk     = 1'b0;
        i2s_d         = 1'b0;
        audio_control = '0;
        gain_select   = '0;
        gain_lsb      = '0;
        gain_msb      = '0;
        gain_wr_en    = 1'b0;
        fill_table();
        timeout_limit = num_rows * 8 * dac_frame_clk;       // drains and gain writes
        for (int i = 0; i < num_rows; i++)
            timeout_limit += stim_rows[i].frames * dac_frame_clk;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < num_rows; i++)
            run_row(stim_rows[i]);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
